// File: hw/divTypesPkg.sv
/*
 * Division type definitions
 * Opcodes carried on the bus address and the slave control states
 */

package divTypesPkg;

    // Opcode on the Wishbone address
    typedef enum logic [1:0] {
        DIV  = 2'd0, // Signed quotient
        DIVU = 2'd1, // Unsigned quotient
        REM  = 2'd2, // Signed remainder
        REMU = 2'd3  // Unsigned remainder
    } DivOp;

    // Slave control FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0, // Waiting for a strobe
        BUSY    = 2'd1, // Operands in the divider pipeline
        RESPOND = 2'd2, // Ack with the selected result
        ERROR   = 2'd3  // Err for a read cycle
    } SlavePhase;

endpackage

// File: hw/wbBusPkg.sv
/*
 * Bus definitions
 * Master count, address width and arbiter ownership state
 */

package wbBusPkg;

    localparam int NUM_MASTERS = 2; // Fixed pair of peer masters
    localparam int ADR_WIDTH   = 2; // Holds one DivOp

    // Current bus owner
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        OWNER0 = 2'd1,
        OWNER1 = 2'd2
    } ArbState;

endpackage

// File: hw/pipelinedDivider.sv
/*
 * Pipelined divider
 * Quotient and remainder computed in one step with RISC-V M rules,
 * then delayed through PIPELINE_DEPTH-1 stall-controlled stages
 */

`timescale 1ns/1ns

module pipelinedDivider #(
    parameter int DATA_WIDTH     = 32,
    parameter int PIPELINE_DEPTH = 3  // Minimum 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,    // All stages hold when high
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    input  logic                  isSigned,
    output logic [DATA_WIDTH-1:0] quotient,
    output logic [DATA_WIDTH-1:0] remainder
);

    localparam int STAGES = PIPELINE_DEPTH - 1;

    // Signed minimum and minus one patterns
    localparam logic [DATA_WIDTH-1:0] MIN_VAL  = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam logic [DATA_WIDTH-1:0] ALL_ONES = '1;

    logic [DATA_WIDTH-1:0] nextQuo;
    logic [DATA_WIDTH-1:0] nextRem;

    logic [DATA_WIDTH-1:0] quoStage [STAGES];
    logic [DATA_WIDTH-1:0] remStage [STAGES];

    // Result before the pipeline
    always_comb begin
        if (divisor == '0) begin
            // Divide by zero
            nextQuo = ALL_ONES;
            nextRem = dividend;
        end else if (isSigned && dividend == MIN_VAL && divisor == ALL_ONES) begin
            // Signed overflow, quotient wraps to the dividend
            nextQuo = dividend;
            nextRem = '0;
        end else if (isSigned) begin
            nextQuo = $signed(dividend) / $signed(divisor); // Truncates toward zero
            nextRem = $signed(dividend) % $signed(divisor); // Sign follows dividend
        end else begin
            nextQuo = dividend / divisor;
            nextRem = dividend % divisor;
        end
    end

    // Shift register, advances only when not stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                quoStage[i] <= '0;
                remStage[i] <= '0;
            end
        end else if (!stall) begin
            quoStage[0] <= nextQuo;
            remStage[0] <= nextRem;
            for (int i = 1; i < STAGES; i++) begin
                quoStage[i] <= quoStage[i-1];
                remStage[i] <= remStage[i-1];
            end
        end
    end

    assign quotient  = quoStage[STAGES-1]; // Last stage
    assign remainder = remStage[STAGES-1];

endmodule

// File: hw/divBusSlave.sv
/*
 * Division bus slave
 * Wishbone classic slave that feeds the divider and acks with the
 * quotient or remainder picked by the opcode; read cycles get err
 */

`timescale 1ns/1ns

module divBusSlave #(
    parameter int DATA_WIDTH     = 32,
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [wbBusPkg::ADR_WIDTH-1:0] adr,         // DivOp
    input  logic [DATA_WIDTH-1:0]          dividend,
    input  logic [DATA_WIDTH-1:0]          divisor,
    output logic [DATA_WIDTH-1:0]          result,
    output logic                           ack,
    output logic                           err,
    output logic                           divStall,
    output logic [DATA_WIDTH-1:0]          divDividend,
    output logic [DATA_WIDTH-1:0]          divDivisor,
    output logic                           divSigned,
    input  logic [DATA_WIDTH-1:0]          divQuotient,
    input  logic [DATA_WIDTH-1:0]          divRemainder
);

    localparam int CNT_W = $clog2(PIPELINE_DEPTH);

    divTypesPkg::SlavePhase phase;
    divTypesPkg::DivOp      opReg;
    logic [CNT_W-1:0]       cnt;        // Cycles spent in BUSY
    logic [DATA_WIDTH-1:0]  dividendReg;
    logic [DATA_WIDTH-1:0]  divisorReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= divTypesPkg::IDLE;
            cnt   <= '0;
        end else begin
            case (phase)
                divTypesPkg::IDLE: begin
                    cnt <= '0;
                    if (cyc && stb) begin
                        phase <= we ? divTypesPkg::BUSY : divTypesPkg::ERROR; // Reads rejected
                    end
                end
                divTypesPkg::BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(PIPELINE_DEPTH - 2)) begin
                        phase <= divTypesPkg::RESPOND; // Result at divider output
                    end
                end
                default: phase <= divTypesPkg::IDLE; // RESPOND and ERROR last one cycle
            endcase
        end
    end

    // Operand and opcode capture on accept
    always_ff @(posedge clk) begin
        if (phase == divTypesPkg::IDLE && cyc && stb && we) begin
            opReg       <= divTypesPkg::DivOp'(adr);
            dividendReg <= dividend;
            divisorReg  <= divisor;
        end
    end

    assign divStall    = (phase != divTypesPkg::BUSY); // Pipeline frozen outside BUSY
    assign divDividend = dividendReg;
    assign divDivisor  = divisorReg;
    assign divSigned   = (opReg == divTypesPkg::DIV) || (opReg == divTypesPkg::REM);

    assign ack = (phase == divTypesPkg::RESPOND);
    assign err = (phase == divTypesPkg::ERROR);

    // Quotient for DIV and DIVU, remainder otherwise
    always_comb begin
        if (!ack) begin
            result = '0;
        end else if (opReg == divTypesPkg::DIV || opReg == divTypesPkg::DIVU) begin
            result = divQuotient;
        end else begin
            result = divRemainder;
        end
    end

endmodule

// File: hw/wbArbiter.sv
/*
 * Wishbone arbiter
 * Round robin between two classic masters with a registered grant
 */

`timescale 1ns/1ns

module wbArbiter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           m0Cyc,
    input  logic                           m0Stb,
    input  logic                           m0We,
    input  logic [wbBusPkg::ADR_WIDTH-1:0] m0Adr,
    input  logic [DATA_WIDTH-1:0]          m0Dividend,
    input  logic [DATA_WIDTH-1:0]          m0Divisor,
    output logic [DATA_WIDTH-1:0]          m0Result,
    output logic                           m0Ack,
    output logic                           m0Err,
    input  logic                           m1Cyc,
    input  logic                           m1Stb,
    input  logic                           m1We,
    input  logic [wbBusPkg::ADR_WIDTH-1:0] m1Adr,
    input  logic [DATA_WIDTH-1:0]          m1Dividend,
    input  logic [DATA_WIDTH-1:0]          m1Divisor,
    output logic [DATA_WIDTH-1:0]          m1Result,
    output logic                           m1Ack,
    output logic                           m1Err,
    output logic                           sCyc,
    output logic                           sStb,
    output logic                           sWe,
    output logic [wbBusPkg::ADR_WIDTH-1:0] sAdr,
    output logic [DATA_WIDTH-1:0]          sDividend,
    output logic [DATA_WIDTH-1:0]          sDivisor,
    input  logic [DATA_WIDTH-1:0]          sResult,
    input  logic                           sAck,
    input  logic                           sErr
);

    wbBusPkg::ArbState               owner;
    logic                            lastServed; // Index of the master served last
    logic [wbBusPkg::NUM_MASTERS-1:0] req;

    assign req = {m1Cyc & m1Stb, m0Cyc & m0Stb};

    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= wbBusPkg::IDLE;
            lastServed <= 1'b1; // Master 0 wins first
        end else begin
            case (owner)
                wbBusPkg::IDLE: begin
                    if (req[0] && (!req[1] || lastServed)) begin
                        owner      <= wbBusPkg::OWNER0;
                        lastServed <= 1'b0;
                    end else if (req[1]) begin
                        owner      <= wbBusPkg::OWNER1;
                        lastServed <= 1'b1;
                    end
                end
                default: begin
                    if (sAck || sErr) begin
                        owner <= wbBusPkg::IDLE; // Released after the response
                    end
                end
            endcase
        end
    end

    // Request path from the owner, quiet bus when idle
    always_comb begin
        sCyc      = 1'b0;
        sStb      = 1'b0;
        sWe       = 1'b0;
        sAdr      = '0;
        sDividend = '0;
        sDivisor  = '0;
        if (owner == wbBusPkg::OWNER0) begin
            sCyc      = m0Cyc;
            sStb      = m0Stb;
            sWe       = m0We;
            sAdr      = m0Adr;
            sDividend = m0Dividend;
            sDivisor  = m0Divisor;
        end else if (owner == wbBusPkg::OWNER1) begin
            sCyc      = m1Cyc;
            sStb      = m1Stb;
            sWe       = m1We;
            sAdr      = m1Adr;
            sDividend = m1Dividend;
            sDivisor  = m1Divisor;
        end
    end

    // Responses go only to the owner
    assign m0Ack    = sAck && (owner == wbBusPkg::OWNER0);
    assign m0Err    = sErr && (owner == wbBusPkg::OWNER0);
    assign m0Result = (owner == wbBusPkg::OWNER0) ? sResult : '0;
    assign m1Ack    = sAck && (owner == wbBusPkg::OWNER1);
    assign m1Err    = sErr && (owner == wbBusPkg::OWNER1);
    assign m1Result = (owner == wbBusPkg::OWNER1) ? sResult : '0;

endmodule

// File: hw/divSubsystemTop.sv
/*
 * Shared division subsystem
 * Two master ports, round-robin arbiter, bus slave and divider
 */

`timescale 1ns/1ns

module divSubsystemTop #(
    parameter int DATA_WIDTH     = 32,
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           m0Cyc,
    input  logic                           m0Stb,
    input  logic                           m0We,
    input  logic [wbBusPkg::ADR_WIDTH-1:0] m0Adr,
    input  logic [DATA_WIDTH-1:0]          m0Dividend,
    input  logic [DATA_WIDTH-1:0]          m0Divisor,
    output logic [DATA_WIDTH-1:0]          m0Result,
    output logic                           m0Ack,
    output logic                           m0Err,
    input  logic                           m1Cyc,
    input  logic                           m1Stb,
    input  logic                           m1We,
    input  logic [wbBusPkg::ADR_WIDTH-1:0] m1Adr,
    input  logic [DATA_WIDTH-1:0]          m1Dividend,
    input  logic [DATA_WIDTH-1:0]          m1Divisor,
    output logic [DATA_WIDTH-1:0]          m1Result,
    output logic                           m1Ack,
    output logic                           m1Err
);

    // Slave-side bus
    logic                           sCyc;
    logic                           sStb;
    logic                           sWe;
    logic [wbBusPkg::ADR_WIDTH-1:0] sAdr;
    logic [DATA_WIDTH-1:0]          sDividend;
    logic [DATA_WIDTH-1:0]          sDivisor;
    logic [DATA_WIDTH-1:0]          sResult;
    logic                           sAck;
    logic                           sErr;

    // Slave to divider
    logic                  divStall;
    logic [DATA_WIDTH-1:0] divDividend;
    logic [DATA_WIDTH-1:0] divDivisor;
    logic                  divSigned;
    logic [DATA_WIDTH-1:0] divQuotient;
    logic [DATA_WIDTH-1:0] divRemainder;

    // Arbiter has exactly two master groups and the divider needs one stage
    if (wbBusPkg::NUM_MASTERS != 2) begin : gBadMasterCount
        $error("divSubsystemTop supports exactly two masters");
    end
    if (PIPELINE_DEPTH < 2) begin : gBadDepth
        $error("PIPELINE_DEPTH must be at least 2");
    end

    wbArbiter #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_arbiter (
        .clk(clk), .rst(rst),
        .m0Cyc(m0Cyc), .m0Stb(m0Stb), .m0We(m0We), .m0Adr(m0Adr),
        .m0Dividend(m0Dividend), .m0Divisor(m0Divisor),
        .m0Result(m0Result), .m0Ack(m0Ack), .m0Err(m0Err),
        .m1Cyc(m1Cyc), .m1Stb(m1Stb), .m1We(m1We), .m1Adr(m1Adr),
        .m1Dividend(m1Dividend), .m1Divisor(m1Divisor),
        .m1Result(m1Result), .m1Ack(m1Ack), .m1Err(m1Err),
        .sCyc(sCyc), .sStb(sStb), .sWe(sWe), .sAdr(sAdr),
        .sDividend(sDividend), .sDivisor(sDivisor),
        .sResult(sResult), .sAck(sAck), .sErr(sErr)
    );

    divBusSlave #(
        .DATA_WIDTH(DATA_WIDTH),
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) u_slave (
        .clk(clk), .rst(rst),
        .cyc(sCyc), .stb(sStb), .we(sWe), .adr(sAdr),
        .dividend(sDividend), .divisor(sDivisor),
        .result(sResult), .ack(sAck), .err(sErr),
        .divStall(divStall), .divDividend(divDividend), .divDivisor(divDivisor),
        .divSigned(divSigned), .divQuotient(divQuotient), .divRemainder(divRemainder)
    );

    pipelinedDivider #(
        .DATA_WIDTH(DATA_WIDTH),
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) u_divider (
        .clk(clk), .rst(rst), .stall(divStall),
        .dividend(divDividend), .divisor(divDivisor), .isSigned(divSigned),
        .quotient(divQuotient), .remainder(divRemainder)
    );

endmodule

// File: verif/divSubsystem_sva.sv
/*
 * Bus protocol assertions
 * Bound into the division slave and the arbiter
 */

`timescale 1ns/1ns

module divSubsystem_sva (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic err,
    input logic stb,
    input logic grant0, // Ownership flags, tied low in the slave
    input logic grant1,
    input logic req0,   // Master requests, tied low in the slave
    input logic req1
);

    // A response is either ack or err, never both
    assert property (@(posedge clk) disable iff (rst) !(ack && err))
        else $error("ack and err asserted together");

    assert property (@(posedge clk) disable iff (rst) ack |-> stb) // Classic handshake
        else $error("ack raised without stb");

    // Only a requesting master holds the bus
    assert property (@(posedge clk) disable iff (rst) (!grant0 || req0) && (!grant1 || req1))
        else $error("bus owned by a master that does not request it");

    // Ownership passes through idle, one owner at a time
    assert property (@(posedge clk) disable iff (rst)
        !(grant0 && $past(grant1)) && !(grant1 && $past(grant0)))
        else $error("ownership moved between masters without a release");

endmodule

bind divBusSlave divSubsystem_sva u_slaveSva (
    .clk(clk), .rst(rst), .ack(ack), .err(err), .stb(stb),
    .grant0(1'b0), .grant1(1'b0), .req0(1'b0), .req1(1'b0)
);

bind wbArbiter divSubsystem_sva u_arbSva (
    .clk(clk), .rst(rst), .ack(sAck), .err(sErr), .stb(sStb),
    .grant0(owner == wbBusPkg::OWNER0), .grant1(owner == wbBusPkg::OWNER1),
    .req0(req[0]), .req1(req[1])
);

// File: verif/divScoreboard.sv
/*
 * Response checker
 * Compares ack, err and result on both master ports with the
 * expected values of the running test, checks the served order
 * of paired requests and keeps the totals
 */

`timescale 1ns/1ns

module divScoreboard #(
    parameter int DATA_WIDTH = 32,
    parameter int NAME_W     = 128
) (
    input  logic                  clk,
    input  logic                  m0Ack,
    input  logic                  m0Err,
    input  logic [DATA_WIDTH-1:0] m0Result,
    input  logic                  m1Ack,
    input  logic                  m1Err,
    input  logic [DATA_WIDTH-1:0] m1Result,
    input  logic                  exp0Valid,  // Master 0 has a request outstanding
    input  logic [NAME_W-1:0]     exp0Name,
    input  logic                  exp0Err,
    input  logic [DATA_WIDTH-1:0] exp0Result,
    input  logic                  exp1Valid,
    input  logic [NAME_W-1:0]     exp1Name,
    input  logic                  exp1Err,
    input  logic [DATA_WIDTH-1:0] exp1Result,
    input  logic                  orderValid, // Paired request in flight
    input  logic                  orderFirst, // Master expected to be served first
    input  logic                  runDone,
    input  logic                  timedOut,
    output int                    passCount,
    output int                    failCount
);

    logic orderSeen;   // First response of the pair already seen
    logic firstMaster;

    initial begin
        passCount = 0;
        failCount = 0;
        orderSeen = 1'b0;
    end

    task automatic checkPort(
        input int                    m,
        input logic                  valid,
        input logic [NAME_W-1:0]     name,
        input logic                  expErr,
        input logic [DATA_WIDTH-1:0] expRes,
        input logic                  ack,
        input logic                  err,
        input logic [DATA_WIDTH-1:0] res
    );
        if (!valid) begin
            // Also covers stray responses during and after reset
            $display("Master %0d gave ack or err with no request outstanding", m);
            failCount++;
        end else if (expErr) begin
            // Err carries no result
            if (err && !ack && res === expRes) begin
                $display("Pass %s: err as expected", name);
                passCount++;
            end else begin
                $display("Error %s: expected err with %h, actual ack %b err %b result %h",
                         name, expRes, ack, err, res);
                failCount++;
            end
        end else if (ack && !err && res === expRes) begin
            $display("Pass %s: result %h", name, res);
            passCount++;
        end else begin
            $display("Error %s: expected %h, actual %h (err %b)", name, expRes, res, err);
            failCount++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (m0Ack || m0Err) begin
            checkPort(0, exp0Valid, exp0Name, exp0Err, exp0Result, m0Ack, m0Err, m0Result);
        end
        if (m1Ack || m1Err) begin
            checkPort(1, exp1Valid, exp1Name, exp1Err, exp1Result, m1Ack, m1Err, m1Result);
        end
        if (!orderValid) begin
            orderSeen = 1'b0;
        end else if (!orderSeen && (m0Ack || m0Err || m1Ack || m1Err)) begin
            orderSeen   = 1'b1;
            firstMaster = (m0Ack || m0Err) ? 1'b0 : 1'b1;
            if (firstMaster != orderFirst) begin
                $display("Error %s: expected master %0d served first, actual master %0d",
                         firstMaster ? exp1Name : exp0Name, orderFirst, firstMaster);
                failCount++;
            end
        end
    end

    always @(posedge runDone) begin
        $display("Totals: %0d passed, %0d failed, timeout %0d", passCount, failCount, timedOut);
    end

endmodule

// File: verif/divSubsystemTb.sv
/*
 * Testbench for the shared division subsystem
 * Table of operations on two Wishbone masters, paired requests
 * for arbitration order, and seeded random rows
 */

`timescale 1ns/1ns

module divSubsystemTb;

    localparam int DATA_WIDTH     = 32;
    localparam int PIPELINE_DEPTH = 3;
    localparam int NAME_W         = 128; // 16 characters
    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_ROWS    = 8;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           m0Cyc;
    logic                           m0Stb;
    logic                           m0We;
    logic [wbBusPkg::ADR_WIDTH-1:0] m0Adr;
    logic [DATA_WIDTH-1:0]          m0Dividend;
    logic [DATA_WIDTH-1:0]          m0Divisor;
    logic [DATA_WIDTH-1:0]          m0Result;
    logic                           m0Ack;
    logic                           m0Err;
    logic                           m1Cyc;
    logic                           m1Stb;
    logic                           m1We;
    logic [wbBusPkg::ADR_WIDTH-1:0] m1Adr;
    logic [DATA_WIDTH-1:0]          m1Dividend;
    logic [DATA_WIDTH-1:0]          m1Divisor;
    logic [DATA_WIDTH-1:0]          m1Result;
    logic                           m1Ack;
    logic                           m1Err;

    // Expected values handed to the scoreboard
    logic                  exp0Valid;
    logic [NAME_W-1:0]     exp0Name;
    logic                  exp0Err;
    logic [DATA_WIDTH-1:0] exp0Result;
    logic                  exp1Valid;
    logic [NAME_W-1:0]     exp1Name;
    logic                  exp1Err;
    logic [DATA_WIDTH-1:0] exp1Result;
    logic                  orderValid;
    logic                  orderFirst;
    logic                  runDone;
    logic                  timedOut;
    logic                  lastServed; // Arbiter model, master served last
    int                    passCount;
    int                    failCount;
    int                    seed = 68;

    // Stimulus table, one entry per operation
    logic [NAME_W-1:0]     nameQ[$];
    logic                  masterQ[$];
    logic                  simQ[$];    // Launched together with the next entry
    divTypesPkg::DivOp     opQ[$];
    logic                  weQ[$];
    logic [DATA_WIDTH-1:0] dividendQ[$];
    logic [DATA_WIDTH-1:0] divisorQ[$];
    logic [DATA_WIDTH-1:0] expectQ[$];
    logic                  errQ[$];

    always #2 clk = ~clk;

    divSubsystemTop #(
        .DATA_WIDTH(DATA_WIDTH),
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) u_dut (
        .clk(clk), .rst(rst),
        .m0Cyc(m0Cyc), .m0Stb(m0Stb), .m0We(m0We), .m0Adr(m0Adr),
        .m0Dividend(m0Dividend), .m0Divisor(m0Divisor),
        .m0Result(m0Result), .m0Ack(m0Ack), .m0Err(m0Err),
        .m1Cyc(m1Cyc), .m1Stb(m1Stb), .m1We(m1We), .m1Adr(m1Adr),
        .m1Dividend(m1Dividend), .m1Divisor(m1Divisor),
        .m1Result(m1Result), .m1Ack(m1Ack), .m1Err(m1Err)
    );

    divScoreboard #(
        .DATA_WIDTH(DATA_WIDTH),
        .NAME_W(NAME_W)
    ) u_scoreboard (
        .clk(clk),
        .m0Ack(m0Ack), .m0Err(m0Err), .m0Result(m0Result),
        .m1Ack(m1Ack), .m1Err(m1Err), .m1Result(m1Result),
        .exp0Valid(exp0Valid), .exp0Name(exp0Name), .exp0Err(exp0Err),
        .exp0Result(exp0Result),
        .exp1Valid(exp1Valid), .exp1Name(exp1Name), .exp1Err(exp1Err),
        .exp1Result(exp1Result),
        .orderValid(orderValid), .orderFirst(orderFirst),
        .runDone(runDone), .timedOut(timedOut),
        .passCount(passCount), .failCount(failCount)
    );

    // Reference from the RISC-V M rules, via magnitudes and signs
    function automatic logic [DATA_WIDTH-1:0] refDivide(
        input divTypesPkg::DivOp     op,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        logic                  isSigned;
        logic                  wantQuo;
        logic [DATA_WIDTH-1:0] magA;
        logic [DATA_WIDTH-1:0] magB;
        logic [DATA_WIDTH-1:0] quo;
        logic [DATA_WIDTH-1:0] rem;
        isSigned = (op == divTypesPkg::DIV) || (op == divTypesPkg::REM);
        wantQuo  = (op == divTypesPkg::DIV) || (op == divTypesPkg::DIVU);
        if (b == '0) begin
            quo = '1;  // Divide by zero
            rem = a;
        end else begin
            magA = (isSigned && a[DATA_WIDTH-1]) ? -a : a;
            magB = (isSigned && b[DATA_WIDTH-1]) ? -b : b;
            quo  = magA / magB;
            rem  = magA % magB;
            if (isSigned && (a[DATA_WIDTH-1] != b[DATA_WIDTH-1])) begin
                quo = -quo; // Truncation toward zero, also wraps MIN / -1
            end
            if (isSigned && a[DATA_WIDTH-1]) begin
                rem = -rem; // Remainder takes the dividend's sign
            end
        end
        return wantQuo ? quo : rem;
    endfunction

    function automatic void addRow(
        input logic [NAME_W-1:0]     name,
        input logic                  m,
        input logic                  sim,
        input divTypesPkg::DivOp     op,
        input logic                  we,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b,
        input logic [DATA_WIDTH-1:0] expected,
        input logic                  err
    );
        nameQ.push_back(name);
        masterQ.push_back(m);
        simQ.push_back(sim);
        opQ.push_back(op);
        weQ.push_back(we);
        dividendQ.push_back(a);
        divisorQ.push_back(b);
        expectQ.push_back(expected);
        errQ.push_back(err);
    endfunction

    task automatic buildTable();
        logic [DATA_WIDTH-1:0] rndA;
        logic [DATA_WIDTH-1:0] rndB;
        logic [31:0]           rndSel;
        divTypesPkg::DivOp     op;
        // name, master, paired, op, we, dividend, divisor, expected, err
        addRow("pair_div", 1'b0, 1'b1, divTypesPkg::DIV, 1'b1,
               32'hFFFFFFF9, 32'd2, 32'hFFFFFFFD, 1'b0);
        addRow("pair_rem", 1'b1, 1'b0, divTypesPkg::REM, 1'b1,
               32'hFFFFFFF9, 32'd2, 32'hFFFFFFFF, 1'b0);
        addRow("divu_neg", 1'b1, 1'b0, divTypesPkg::DIVU, 1'b1,
               32'hFFFFFFF9, 32'd2, 32'h7FFFFFFC, 1'b0);
        addRow("remu_neg", 1'b0, 1'b0, divTypesPkg::REMU, 1'b1,
               32'hFFFFFFF9, 32'd2, 32'h00000001, 1'b0);
        addRow("div_negdivisor", 1'b0, 1'b0, divTypesPkg::DIV, 1'b1,
               32'd100, 32'hFFFFFFF9, 32'hFFFFFFF2, 1'b0);
        addRow("rem_negdivisor", 1'b1, 1'b0, divTypesPkg::REM, 1'b1,
               32'd100, 32'hFFFFFFF9, 32'd2, 1'b0);
        addRow("div_zero", 1'b0, 1'b0, divTypesPkg::DIV, 1'b1,
               32'h12345678, 32'd0, 32'hFFFFFFFF, 1'b0);
        addRow("divu_zero", 1'b1, 1'b0, divTypesPkg::DIVU, 1'b1,
               32'h12345678, 32'd0, 32'hFFFFFFFF, 1'b0);
        addRow("rem_zero", 1'b0, 1'b0, divTypesPkg::REM, 1'b1,
               32'h12345678, 32'd0, 32'h12345678, 1'b0);
        addRow("remu_zero", 1'b1, 1'b0, divTypesPkg::REMU, 1'b1,
               32'h80000001, 32'd0, 32'h80000001, 1'b0);
        addRow("div_overflow", 1'b0, 1'b0, divTypesPkg::DIV, 1'b1,
               32'h80000000, 32'hFFFFFFFF, 32'h80000000, 1'b0);
        addRow("rem_overflow", 1'b1, 1'b0, divTypesPkg::REM, 1'b1,
               32'h80000000, 32'hFFFFFFFF, 32'd0, 1'b0);
        addRow("divu_minval", 1'b1, 1'b0, divTypesPkg::DIVU, 1'b1,
               32'h80000000, 32'hFFFFFFFF, 32'd0, 1'b0);
        addRow("read_cycle", 1'b0, 1'b0, divTypesPkg::DIV, 1'b0,
               32'd10, 32'd3, 32'd0, 1'b1);
        addRow("div_after_err", 1'b0, 1'b0, divTypesPkg::DIV, 1'b1,
               32'd10, 32'd3, 32'd3, 1'b0);
        // Master 0 was served last, so master 1 wins this pair
        addRow("pair_divu", 1'b0, 1'b1, divTypesPkg::DIVU, 1'b1,
               32'd1000, 32'd10, 32'd100, 1'b0);
        addRow("pair_remu", 1'b1, 1'b0, divTypesPkg::REMU, 1'b1,
               32'd1000, 32'd7, 32'd6, 1'b0);
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            rndA   = $random(seed);
            rndB   = $random(seed);
            rndSel = $random(seed);
            if (rndSel[3]) begin
                rndB = {{24{rndB[7]}}, rndB[7:0]}; // Small divisor of either sign
            end
            op = divTypesPkg::DivOp'(rndSel[1:0]);
            addRow(NAME_W'({"random_", 8'(8'h30 + k)}), rndSel[2], 1'b0, op, 1'b1,
                   rndA, rndB, refDivide(op, rndA, rndB), 1'b0);
        end
    endtask

    task automatic driveMaster(input logic m, input int r);
        if (m == 1'b0) begin
            m0Cyc      <= 1'b1;
            m0Stb      <= 1'b1;
            m0We       <= weQ[r];
            m0Adr      <= opQ[r];
            m0Dividend <= dividendQ[r];
            m0Divisor  <= divisorQ[r];
            exp0Valid  <= 1'b1;
            exp0Name   <= nameQ[r];
            exp0Err    <= errQ[r];
            exp0Result <= expectQ[r];
        end else begin
            m1Cyc      <= 1'b1;
            m1Stb      <= 1'b1;
            m1We       <= weQ[r];
            m1Adr      <= opQ[r];
            m1Dividend <= dividendQ[r];
            m1Divisor  <= divisorQ[r];
            exp1Valid  <= 1'b1;
            exp1Name   <= nameQ[r];
            exp1Err    <= errQ[r];
            exp1Result <= expectQ[r];
        end
    endtask

    task automatic releaseMaster(input logic m);
        if (m == 1'b0) begin
            m0Cyc     <= 1'b0;
            m0Stb     <= 1'b0;
            exp0Valid <= 1'b0;
        end else begin
            m1Cyc     <= 1'b0;
            m1Stb     <= 1'b0;
            exp1Valid <= 1'b0;
        end
    endtask

    // Launch one entry, or a pair in the same cycle, and wait for all responses
    task automatic runRows(input int first, input int count);
        logic [1:0] want;
        logic [1:0] got;
        logic [1:0] seen;
        int         cycles;
        want   = 2'b00;
        got    = 2'b00;
        cycles = 0;
        @(posedge clk);
        for (int k = 0; k < count; k++) begin
            driveMaster(masterQ[first + k], first + k);
            want[masterQ[first + k]] = 1'b1;
        end
        if (count == 2) begin
            orderValid <= 1'b1;
            orderFirst <= ~lastServed; // The one not served last wins
        end
        while (got != want && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            seen = {m1Ack | m1Err, m0Ack | m0Err} & want & ~got;
            @(posedge clk);
            if (seen[0]) begin
                releaseMaster(1'b0);
                lastServed = 1'b0;
            end
            if (seen[1]) begin
                releaseMaster(1'b1);
                lastServed = 1'b1;
            end
            got    = got | seen;
            cycles = cycles + 1;
        end
        orderValid <= 1'b0;
        if (got != want) begin
            $display("Timeout: no ack or err within %0d cycles for %s", TIMEOUT_CYCLES,
                     nameQ[first]);
            timedOut = 1'b1;
        end
    endtask

    initial begin
        int row;
        rst        = 1'b1;
        m0Cyc      = 1'b0;
        m0Stb      = 1'b0;
        m0We       = 1'b0;
        m0Adr      = '0;
        m0Dividend = '0;
        m0Divisor  = '0;
        m1Cyc      = 1'b0;
        m1Stb      = 1'b0;
        m1We       = 1'b0;
        m1Adr      = '0;
        m1Dividend = '0;
        m1Divisor  = '0;
        exp0Valid  = 1'b0;
        exp0Name   = '0;
        exp0Err    = 1'b0;
        exp0Result = '0;
        exp1Valid  = 1'b0;
        exp1Name   = '0;
        exp1Err    = 1'b0;
        exp1Result = '0;
        orderValid = 1'b0;
        orderFirst = 1'b0;
        runDone    = 1'b0;
        timedOut   = 1'b0;
        lastServed = 1'b1; // Master 0 wins the first pair after reset
        buildTable();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk); // Idle bus right after reset
        row = 0;
        while (row < nameQ.size() && !timedOut) begin
            if (simQ[row]) begin
                runRows(row, 2);
                row = row + 2;
            end else begin
                runRows(row, 1);
                row = row + 1;
            end
        end
        repeat (3) @(posedge clk);
        runDone <= 1'b1;
        @(negedge clk);
        if (failCount == 0 && !timedOut) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/divTypesPkg.sv
hw/wbBusPkg.sv
hw/pipelinedDivider.sv
hw/divBusSlave.sv
hw/wbArbiter.sv
hw/divSubsystemTop.sv
verif/divSubsystem_sva.sv
verif/divScoreboard.sv
verif/divSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= divSubsystemTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
